// ==== Bender.yml ====
package:
  name: sram_axi_bridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_bridge_pkg.sv
      - hdl/ar_channel.sv
      - hdl/aw_w_channel.sv
      - hdl/sram_axi_bridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/axi_slave_model.sv
      - test/tb_sram_axi_bridge.sv

// ==== hdl/ar_channel.sv ====
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module ar_channel (
    input  logic                      clk,
    input  logic                      resetn,
    input  axi_bridge_pkg::sram_req_t inst_req,
    input  axi_bridge_pkg::sram_req_t data_req,
    input  logic                      arready,
    output axi_bridge_pkg::axi_a_t    ar,
    output logic                      arvalid,
    output logic                      inst_addr_ok,
    output logic                      data_rd_addr_ok
);
    import axi_bridge_pkg::*;

    ar_state_t state;
    ar_state_t state_next;
    logic      data_rd;
    logic      any_rd;
    logic      ar_stall;
    axi_a_t    ar_new;
    axi_a_t    ar_held;

    // data port is a read only when wr is low
    assign data_rd = data_req.req && !data_req.wr;
    assign any_rd  = inst_req.req || data_rd;

    // beat in the holding register not yet taken by the slave
    assign ar_stall = (state == ar_wait) && !arready;

    // request to issue, data read wins
    always_comb begin
        ar_new       = '0;
        ar_new.len   = `LEN_W'(`LEN_SINGLE);
        ar_new.burst = 2'(`BURST_INCR);
        if (data_rd) begin
            ar_new.id   = `ID_W'(`DATA_ID);
            ar_new.addr = data_req.addr;
            ar_new.size = {1'b0, data_req.size};
        end else begin
            ar_new.id   = `ID_W'(`INST_ID);
            ar_new.addr = inst_req.addr;
            ar_new.size = {1'b0, inst_req.size};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ar_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ar_idle: begin
                // slave did not take the direct beat, replay from the register
                if (any_rd && !arready) begin
                    state_next = ar_wait;
                end
            end
            ar_wait: begin
                // a read accepted on the arready cycle keeps us here
                if (arready && !any_rd) begin
                    state_next = ar_idle;
                end
            end
            default: begin
                state_next = ar_idle;
            end
        endcase
    end

    // copy of every accepted read
    always_ff @(posedge clk) begin
        if (!ar_stall && any_rd) begin
            ar_held <= ar_new;
        end
    end

    // idle drives the request straight through
    assign ar      = (state == ar_idle) ? ar_new : ar_held;
    assign arvalid = (state == ar_wait) || ((state == ar_idle) && any_rd);

    assign inst_addr_ok    = inst_req.req && !data_rd && !ar_stall;
    assign data_rd_addr_ok = data_rd && !ar_stall;

endmodule

// ==== hdl/aw_w_channel.sv ====
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module aw_w_channel (
    input  logic                      clk,
    input  logic                      resetn,
    input  axi_bridge_pkg::sram_req_t data_req,
    input  logic                      awready,
    input  logic                      wready,
    output axi_bridge_pkg::axi_a_t    aw,
    output axi_bridge_pkg::axi_w_t    w,
    output logic                      awvalid,
    output logic                      wvalid,
    output logic                      data_wr_addr_ok
);
    import axi_bridge_pkg::*;

    aw_w_state_t state;
    aw_w_state_t state_next;
    logic        wr_req;
    logic        wr_stall;
    axi_a_t      aw_new;
    axi_w_t      w_new;
    axi_a_t      aw_held;
    axi_w_t      w_held;

    assign wr_req = data_req.req && data_req.wr;

    // some beat of the last write is still pending at the slave
    assign wr_stall = ((state == aw_w_wait_both) && !(awready && wready))
                   || ((state == aw_w_wait_aw) && !awready)
                   || ((state == aw_w_wait_w) && !wready);

    always_comb begin
        aw_new       = '0;
        aw_new.id    = `ID_W'(`DATA_ID);
        aw_new.addr  = data_req.addr;
        aw_new.len   = `LEN_W'(`LEN_SINGLE);
        aw_new.size  = {1'b0, data_req.size};
        aw_new.burst = 2'(`BURST_INCR);
    end

    // single beat, so wlast always set
    always_comb begin
        w_new      = '0;
        w_new.id   = `ID_W'(`DATA_ID);
        w_new.data = data_req.wdata;
        w_new.strb = data_req.wstrb;
        w_new.last = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= aw_w_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            aw_w_idle: begin
                if (wr_req) begin
                    if (!awready && !wready) begin
                        state_next = aw_w_wait_both;
                    end else if (!awready) begin
                        state_next = aw_w_wait_aw;
                    end else if (!wready) begin
                        state_next = aw_w_wait_w;
                    end
                end
            end
            aw_w_wait_both: begin
                if (awready && wready) begin
                    // next write may be accepted in the same cycle
                    state_next = wr_req ? aw_w_wait_both : aw_w_idle;
                end else if (awready) begin
                    state_next = aw_w_wait_w;
                end else if (wready) begin
                    state_next = aw_w_wait_aw;
                end
            end
            aw_w_wait_aw: begin
                if (awready) begin
                    state_next = wr_req ? aw_w_wait_both : aw_w_idle;
                end
            end
            aw_w_wait_w: begin
                if (wready) begin
                    state_next = wr_req ? aw_w_wait_both : aw_w_idle;
                end
            end
            default: begin
                state_next = aw_w_idle;
            end
        endcase
    end

    // payload of the accepted write, stable while either beat waits
    always_ff @(posedge clk) begin
        if (!wr_stall && wr_req) begin
            aw_held <= aw_new;
            w_held  <= w_new;
        end
    end

    assign aw = (state == aw_w_idle) ? aw_new : aw_held;
    assign w  = (state == aw_w_idle) ? w_new : w_held;

    assign awvalid = (state == aw_w_wait_both) || (state == aw_w_wait_aw)
                  || ((state == aw_w_idle) && wr_req);
    assign wvalid  = (state == aw_w_wait_both) || (state == aw_w_wait_w)
                  || ((state == aw_w_idle) && wr_req);

    assign data_wr_addr_ok = wr_req && !wr_stall;

endmodule

// ==== hdl/axi_bridge_consts.svh ====
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// axi field widths
`define ID_W   4
`define LEN_W  8
`define RESP_W 2

// fixed transaction ids
// instruction reads only
`define INST_ID 0
// data reads and all writes
`define DATA_ID 1

// fixed axi attributes, every transfer is one beat
`define BURST_INCR 1
`define LEN_SINGLE 0

`endif

// ==== hdl/axi_bridge_pkg.sv ====
`include "axi_bridge_consts.svh"

package axi_bridge_pkg;

    // sram-like request, held by the master until addr_ok
    typedef struct packed {
        logic               req;
        logic               wr;
        logic [1:0]         size;
        logic [`STRB_W-1:0] wstrb;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic               addr_ok;
        logic               data_ok;
        logic [`DATA_W-1:0] rdata;
    } sram_resp_t;

    // address channel, same layout for ar and aw
    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]  len;
        logic [2:0]         size;
        logic [1:0]         burst;
        logic [1:0]         lock;
        logic [3:0]         cache;
        logic [2:0]         prot;
    } axi_a_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`DATA_W-1:0] data;
        logic [`STRB_W-1:0] strb;
        logic               last;
    } axi_w_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`DATA_W-1:0] data;
        logic [`RESP_W-1:0] resp;
        logic               last;
    } axi_r_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`RESP_W-1:0] resp;
    } axi_b_t;

    typedef enum logic {
        ar_idle,
        ar_wait
    } ar_state_t;

    // which of aw and w still owe a beat
    typedef enum logic [1:0] {
        aw_w_idle,
        aw_w_wait_both,
        aw_w_wait_aw,
        aw_w_wait_w
    } aw_w_state_t;

endpackage

// ==== hdl/sram_axi_bridge.sv ====
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module sram_axi_bridge (
    input  logic                       clk,
    input  logic                       resetn,

    // instruction port, reads only
    input  axi_bridge_pkg::sram_req_t  inst_req,
    output axi_bridge_pkg::sram_resp_t inst_resp,

    // data port
    input  axi_bridge_pkg::sram_req_t  data_req,
    output axi_bridge_pkg::sram_resp_t data_resp,

    output axi_bridge_pkg::axi_a_t     ar,
    output logic                       arvalid,
    input  logic                       arready,

    input  axi_bridge_pkg::axi_r_t     r,
    input  logic                       rvalid,
    output logic                       rready,

    output axi_bridge_pkg::axi_a_t     aw,
    output logic                       awvalid,
    input  logic                       awready,

    output axi_bridge_pkg::axi_w_t     w,
    output logic                       wvalid,
    input  logic                       wready,

    input  axi_bridge_pkg::axi_b_t     b,
    input  logic                       bvalid,
    output logic                       bready
);
    import axi_bridge_pkg::*;

    logic inst_addr_ok;
    logic data_rd_addr_ok;
    logic data_wr_addr_ok;
    logic r_is_inst;
    logic r_is_data;

    ar_channel u_ar_channel (
        .clk             (clk),
        .resetn          (resetn),
        .inst_req        (inst_req),
        .data_req        (data_req),
        .arready         (arready),
        .ar              (ar),
        .arvalid         (arvalid),
        .inst_addr_ok    (inst_addr_ok),
        .data_rd_addr_ok (data_rd_addr_ok)
    );

    aw_w_channel u_aw_w_channel (
        .clk             (clk),
        .resetn          (resetn),
        .data_req        (data_req),
        .awready         (awready),
        .wready          (wready),
        .aw              (aw),
        .w               (w),
        .awvalid         (awvalid),
        .wvalid          (wvalid),
        .data_wr_addr_ok (data_wr_addr_ok)
    );

    // responses are never back-pressured
    assign rready = 1'b1;
    assign bready = 1'b1;

    // steer R by id
    assign r_is_inst = rvalid && (r.id == `ID_W'(`INST_ID));
    assign r_is_data = rvalid && (r.id == `ID_W'(`DATA_ID));

    assign inst_resp.addr_ok = inst_addr_ok;
    assign inst_resp.data_ok = r_is_inst;
    assign inst_resp.rdata   = r.data;

    // a data R and a B in the same cycle would merge into one data_ok
    assign data_resp.addr_ok = data_rd_addr_ok || data_wr_addr_ok;
    assign data_resp.data_ok = r_is_data || (bvalid && (b.id == `ID_W'(`DATA_ID)));
    assign data_resp.rdata   = r.data;

endmodule

// ==== test/axi_slave_model.sv ====
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module axi_slave_model (
    input  logic                   clk,
    input  logic                   resetn,
    input  axi_bridge_pkg::axi_a_t ar,
    input  logic                   arvalid,
    output logic                   arready,
    output axi_bridge_pkg::axi_r_t r,
    output logic                   rvalid,
    input  axi_bridge_pkg::axi_a_t aw,
    input  logic                   awvalid,
    output logic                   awready,
    input  axi_bridge_pkg::axi_w_t w,
    input  logic                   wvalid,
    output logic                   wready,
    output axi_bridge_pkg::axi_b_t b,
    output logic                   bvalid
);
    import axi_bridge_pkg::*;

    localparam int MEM_AW = 8;

    // one queue for R and B keeps them in separate cycles
    typedef struct packed {
        logic               is_b;
        logic [`ID_W-1:0]   id;
        logic [`DATA_W-1:0] data;
    } slave_resp_t;

    logic [`DATA_W-1:0] mem [1 << MEM_AW];
    logic [1:0]         ar_cnt;
    logic [1:0]         aw_cnt;
    logic [1:0]         w_cnt;
    axi_a_t             aw_pend[$];
    axi_w_t             w_pend[$];
    slave_resp_t        resp_q[$];
    slave_resp_t        rsp;
    axi_a_t             wa;
    axi_w_t             wb;
    axi_r_t             rd;

    // ready comes after 0 to 3 waiting cycles
    assign arready = (ar_cnt == 2'd0);
    assign awready = (aw_cnt == 2'd0);
    assign wready  = (w_cnt == 2'd0);

    initial begin
        void'($urandom(32'h91ba_a7a0));
        // word at byte address a holds c0de0000 | a
        for (int i = 0; i < (1 << MEM_AW); i++) begin
            mem[i] = 32'hc0de_0000 | (i << 2);
        end
        ar_cnt = 2'd0;
        aw_cnt = 2'd0;
        w_cnt  = 2'd0;
        rvalid = 1'b0;
        bvalid = 1'b0;
        r      = '0;
        b      = '0;
        forever begin
            @(posedge clk);
            if (!resetn) begin
                ar_cnt <= 2'd0;
                aw_cnt <= 2'd0;
                w_cnt  <= 2'd0;
                rvalid <= 1'b0;
                bvalid <= 1'b0;
                aw_pend.delete();
                w_pend.delete();
                resp_q.delete();
            end else begin
                if (arvalid && arready) begin
                    rsp = {1'b0, ar.id, mem[ar.addr[MEM_AW+1:2]]};
                    resp_q.push_back(rsp);
                    ar_cnt <= 2'($urandom % 4);
                end else if (arvalid) begin
                    ar_cnt <= ar_cnt - 2'd1;
                end
                if (awvalid && awready) begin
                    aw_pend.push_back(aw);
                    aw_cnt <= 2'($urandom % 4);
                end else if (awvalid) begin
                    aw_cnt <= aw_cnt - 2'd1;
                end
                if (wvalid && wready) begin
                    w_pend.push_back(w);
                    w_cnt <= 2'($urandom % 4);
                end else if (wvalid) begin
                    w_cnt <= w_cnt - 2'd1;
                end
                // write lands once both halves are in
                if (aw_pend.size() > 0 && w_pend.size() > 0) begin
                    wa = aw_pend.pop_front();
                    wb = w_pend.pop_front();
                    for (int k = 0; k < `STRB_W; k++) begin
                        if (wb.strb[k]) begin
                            mem[wa.addr[MEM_AW+1:2]][8*k +: 8] = wb.data[8*k +: 8];
                        end
                    end
                    rsp = {1'b1, wa.id, `DATA_W'(0)};
                    resp_q.push_back(rsp);
                end
                rvalid <= 1'b0;
                bvalid <= 1'b0;
                if (resp_q.size() > 0) begin
                    rsp = resp_q.pop_front();
                    if (rsp.is_b) begin
                        b      <= {rsp.id, 2'b00};
                        bvalid <= 1'b1;
                    end else begin
                        rd      = '0;
                        rd.id   = rsp.id;
                        rd.data = rsp.data;
                        rd.last = 1'b1;
                        r       <= rd;
                        rvalid  <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== test/bridge_golden.txt ====
# port(inst|data|both) op(read|write) addr wdata wstrb expected_rdata, all hex
# slave preload: word at byte address a holds c0de0000 | a
inst read  00000000 00000000 0 c0de0000
inst read  00000004 00000000 0 c0de0004
inst read  00000010 00000000 0 c0de0010
inst read  000003fc 00000000 0 c0de03fc
data read  00000100 00000000 0 c0de0100
data write 00000200 11223344 f 00000000
data read  00000200 00000000 0 11223344
data write 00000204 aabbccdd 3 00000000
data read  00000204 00000000 0 c0deccdd
data write 00000208 55667788 c 00000000
data read  00000208 00000000 0 55660208
data write 0000020c 99aabbcc 5 00000000
data read  0000020c 00000000 0 c0aa02cc
data write 00000210 deadbeef 8 00000000
data read  00000210 00000000 0 dede0210
data write 00000204 01020304 4 00000000
data read  00000204 00000000 0 c002ccdd
both read  00000040 00000000 0 c0de0040
both read  00000080 00000000 0 c0de0080
inst read  00000200 00000000 0 11223344
both read  00000208 00000000 0 55660208
data write 00000300 cafef00d 1 00000000
inst read  00000300 00000000 0 c0de030d
data read  000003fc 00000000 0 c0de03fc
inst read  00000044 00000000 0 c0de0044
data write 00000044 00000000 f 00000000
data read  00000044 00000000 0 00000000
inst read  00000044 00000000 0 00000000

// ==== test/tb_sram_axi_bridge.sv ====
`timescale 1ns/1ps
`include "axi_bridge_consts.svh"

module tb_sram_axi_bridge;
    import axi_bridge_pkg::*;

    // one golden line
    typedef struct packed {
        logic               on_data;
        logic               on_both;
        logic               wr;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [`STRB_W-1:0] strb;
        logic [`DATA_W-1:0] rdata;
    } cmd_t;

    logic       clk;
    logic       resetn;
    sram_req_t  inst_req;
    sram_req_t  data_req;
    sram_resp_t inst_resp;
    sram_resp_t data_resp;
    axi_a_t     ar;
    axi_a_t     aw;
    axi_w_t     w;
    axi_r_t     r;
    axi_b_t     b;
    logic       arvalid;
    logic       arready;
    logic       rvalid;
    logic       rready;
    logic       awvalid;
    logic       awready;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;
    cmd_t       cmds[$];
    bit         loaded;
    // expected beats pushed at acceptance and popped at transfer
    axi_a_t     ar_q[$];
    axi_a_t     aw_q[$];
    axi_w_t     w_q[$];
    logic       ar_pend;
    logic       aw_pend;
    logic       w_pend;
    logic       wr_blocked;
    axi_a_t     ar_prev;
    axi_a_t     aw_prev;
    axi_w_t     w_prev;
    // accepted requests still waiting for data_ok
    int         inst_out;
    int         data_out;

    sram_axi_bridge u_sram_axi_bridge (.*);
    axi_slave_model u_axi_slave_model (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED t=%0t %s expected %b actual %b",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_a(input string name, input axi_a_t exp, input axi_a_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED t=%0t %s expected %h actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_w(input string name, input axi_w_t exp, input axi_w_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED t=%0t %s expected %h actual %h",
                                     $time, name, exp, act));
        end
    endtask

    // rdata only means something for reads
    task automatic check_resp(input string name, input sram_resp_t exp, input sram_resp_t act,
                              input bit with_data);
        if (act.addr_ok !== exp.addr_ok || act.data_ok !== exp.data_ok
                || (with_data && act.rdata !== exp.rdata)) begin
            report_failure($sformatf("FAILED t=%0t %s expected %h actual %h",
                                     $time, name, exp, act));
        end
    endtask

    // single word beat with incr burst and len 0
    function automatic axi_a_t make_a(input logic [`ID_W-1:0] id, input logic [31:0] addr);
        axi_a_t a;
        a       = '0;
        a.id    = id;
        a.addr  = addr;
        a.size  = 3'd2;
        a.burst = 2'b01;
        return a;
    endfunction

    function automatic axi_w_t make_w(input logic [31:0] data, input logic [3:0] strb);
        axi_w_t x;
        x.id   = 4'd1;
        x.data = data;
        x.strb = strb;
        x.last = 1'b1;
        return x;
    endfunction

    task automatic load_golden();
        int                 fd;
        string              line;
        string              port;
        string              op;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [`STRB_W-1:0] strb;
        logic [`DATA_W-1:0] rdata;
        cmd_t               c;
        fd = $fopen("test/bridge_golden.txt", "r");
        if (fd == 0) begin
            report_failure("could not open test/bridge_golden.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 3 && line[0] != "#") begin
                    if ($sscanf(line, "%s %s %h %h %h %h", port, op, addr, wdata, strb,
                                rdata) != 6) begin
                        report_failure({"golden line cannot be parsed: ", line});
                    end else if ((port != "inst" && port != "data" && port != "both")
                            || (op != "read" && op != "write")
                            || (port != "data" && op == "write")) begin
                        report_failure({"golden line has an unknown port or operation: ", line});
                    end else begin
                        c         = '0;
                        c.on_data = (port == "data");
                        c.on_both = (port == "both");
                        c.wr      = (op == "write");
                        c.addr    = addr;
                        c.wdata   = wdata;
                        c.strb    = strb;
                        c.rdata   = rdata;
                        cmds.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one request on one port from issue to data_ok
    task automatic run_port(input bit on_data, input cmd_t c);
        sram_req_t  rq;
        sram_resp_t want;
        bit         seen;
        rq       = '0;
        rq.req   = 1'b1;
        rq.wr    = c.wr;
        rq.size  = 2'd2;
        rq.addr  = c.addr;
        rq.wstrb = c.wr ? c.strb : 4'h0;
        rq.wdata = c.wr ? c.wdata : 32'h0;
        @(posedge clk);
        if (on_data) begin
            data_req <= rq;
        end else begin
            inst_req <= rq;
        end
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = on_data ? data_resp.addr_ok : inst_resp.addr_ok;
        end
        @(posedge clk);
        if (on_data) begin
            data_req <= '0;
        end else begin
            inst_req <= '0;
        end
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = on_data ? data_resp.data_ok : inst_resp.data_ok;
        end
        want = {1'b0, 1'b1, c.rdata};
        if (on_data) begin
            check_resp("data_resp", want, data_resp, !c.wr);
        end else begin
            check_resp("inst_resp", want, inst_resp, 1'b1);
        end
    endtask

    // protocol monitor sampled mid-cycle
    always @(negedge clk) begin
        if (resetn) begin
            check_flag("rready", 1'b1, rready);
            check_flag("bready", 1'b1, bready);
            if (inst_req.req && data_req.req && !data_req.wr) begin
                check_flag("inst_resp.addr_ok", 1'b0, inst_resp.addr_ok);
            end
            if (ar_pend) begin
                check_flag("arvalid", 1'b1, arvalid);
                check_a("ar", ar_prev, ar);
                if (!arready && inst_req.req) begin
                    check_flag("inst_resp.addr_ok", 1'b0, inst_resp.addr_ok);
                end
                if (!arready && data_req.req && !data_req.wr) begin
                    check_flag("data_resp.addr_ok", 1'b0, data_resp.addr_ok);
                end
            end
            if (aw_pend) begin
                check_flag("awvalid", 1'b1, awvalid);
                check_a("aw", aw_prev, aw);
            end
            if (w_pend) begin
                check_flag("wvalid", 1'b1, wvalid);
                check_w("w", w_prev, w);
            end
            // a beat still owed at the slave holds off the next write
            wr_blocked = (aw_pend && !awready) || (w_pend && !wready);
            if (wr_blocked && data_req.req && data_req.wr) begin
                check_flag("data_resp.addr_ok", 1'b0, data_resp.addr_ok);
            end
            // responses go only to the port that asked
            if (inst_resp.data_ok) begin
                if (inst_out == 0) begin
                    report_failure("data_ok on the instruction port with no read outstanding");
                end else begin
                    inst_out--;
                end
            end
            if (data_resp.data_ok) begin
                if (data_out == 0) begin
                    report_failure("data_ok on the data port with no request outstanding");
                end else begin
                    data_out--;
                end
            end
            if (inst_req.req && inst_resp.addr_ok) begin
                inst_out++;
                ar_q.push_back(make_a(4'd0, inst_req.addr));
            end
            if (data_req.req && data_resp.addr_ok) begin
                data_out++;
                if (data_req.wr) begin
                    aw_q.push_back(make_a(4'd1, data_req.addr));
                    w_q.push_back(make_w(data_req.wdata, data_req.wstrb));
                end else begin
                    ar_q.push_back(make_a(4'd1, data_req.addr));
                end
            end
            if (arvalid && arready) begin
                if (ar_q.size() == 0) begin
                    report_failure("AR beat with no accepted read behind it");
                end else begin
                    check_a("ar", ar_q.pop_front(), ar);
                end
            end
            if (awvalid && awready) begin
                if (aw_q.size() == 0) begin
                    report_failure("AW beat with no accepted write behind it");
                end else begin
                    check_a("aw", aw_q.pop_front(), aw);
                end
            end
            if (wvalid && wready) begin
                if (w_q.size() == 0) begin
                    report_failure("W beat with no accepted write behind it");
                end else begin
                    check_w("w", w_q.pop_front(), w);
                end
            end
            ar_pend = arvalid && !arready;
            aw_pend = awvalid && !awready;
            w_pend  = wvalid && !wready;
            ar_prev = ar;
            aw_prev = aw;
            w_prev  = w;
        end
    end

    initial begin
        wait (loaded);
        repeat (cmds.size() * 20) @(posedge clk);
        report_failure($sformatf("timeout, the run did not finish within %0d cycles",
                                 cmds.size() * 20));
    end

    initial begin
        clk      = 1'b0;
        resetn   = 1'b0;
        inst_req = '0;
        data_req = '0;
        ar_pend  = 1'b0;
        aw_pend  = 1'b0;
        w_pend   = 1'b0;
        inst_out = 0;
        data_out = 0;
        load_golden();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        // idle bus before the first request
        @(negedge clk);
        check_flag("arvalid", 1'b0, arvalid);
        check_flag("awvalid", 1'b0, awvalid);
        check_flag("wvalid", 1'b0, wvalid);
        check_flag("inst_resp.addr_ok", 1'b0, inst_resp.addr_ok);
        check_flag("data_resp.addr_ok", 1'b0, data_resp.addr_ok);
        foreach (cmds[i]) begin
            if (cmds[i].on_both) begin
                fork
                    run_port(1'b1, cmds[i]);
                    run_port(1'b0, cmds[i]);
                join
            end else begin
                run_port(cmds[i].on_data, cmds[i]);
            end
        end
        repeat (4) @(posedge clk);
        if (ar_q.size() == 0 && aw_q.size() == 0 && w_q.size() == 0
                && inst_out == 0 && data_out == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure("accepted requests left without an AXI beat or a response");
        end
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/axi_bridge_pkg.sv
hdl/ar_channel.sv
hdl/aw_w_channel.sv
hdl/sram_axi_bridge.sv
test/axi_slave_model.sv
test/tb_sram_axi_bridge.sv
